//--- src/ic_pkg.sv
// shared types and constants for the instruction-cache control unit
// the miss state is one-hot and the fill line is fixed at four words
// acknowledge bit 1 always flags an error, whatever bit 0 says

`default_nettype none

package ic_pkg;

	// *******************************************************************
	// miss state machine encoding
	// *******************************************************************

	// one bit per state, bit 0 is idle
	typedef enum logic [6:0] {
		IDLE           = 7'b000_0001,
		NC_REQ         = 7'b000_0010,
		REQ            = 7'b000_0100,
		FILL_2ND       = 7'b000_1000,
		REQ_2          = 7'b001_0000,
		FILL_4TH       = 7'b010_0000,
		STANDBY_PWR_DN = 7'b100_0000
	} miss_state_e;

	// acknowledge from the bus unit, one word per non-zero cycle
	typedef enum logic [1:0] {
		ACK_NONE      = 2'b00,
		ACK_NORMAL    = 2'b01,
		ACK_ERROR     = 2'b10,
		ACK_ERROR_ALT = 2'b11
	} biu_ack_e;

	// transaction type to the bus unit
	// only bit 1 moves: set for a non-cacheable request
	typedef logic [3:0] ic_type_t;

	// *******************************************************************
	// fetch increment in bytes
	// *******************************************************************

	// 8-bit boot prom, one byte per fetch
	localparam logic [3:0] INC_BOOT = 4'd1;
	// cache off, one word per fetch
	localparam logic [3:0] INC_WORD = 4'd4;
	// cache on, two words per fetch
	localparam logic [3:0] INC_LINE = 4'd8;

endpackage

`default_nettype wire

//--- src/ic_miss_fsm.sv
// miss and power-down FSM of the instruction cache
// the bus unit has no back-pressure: the FSM just waits in a request
// or fill state until an acknowledge arrives, however long it takes
// an error acknowledge aborts a single-word or a line transaction

`timescale 1ns/1ps
`default_nettype none

module ic_miss_fsm (
	input  wire                 clk,
	input  wire                 arst_n,
	input  ic_pkg::biu_ack_e    biu_icu_ack,
	input  wire                 icu_hit,
	input  wire                 iu_brtaken_e,
	input  wire                 ibuf_full,
	input  wire                 pcsu_powerdown,
	input  wire                 iu_psr_bm8,
	input  wire                 cacheable,
	input  wire                 qual_ice,
	input  wire                 standby_d1,
	input  wire                 valid_diag_e,
	input  wire                 valid_diag_c,
	output ic_pkg::miss_state_e miss_state,
	output logic                ic_idle,
	output logic                icu_miss,
	output logic                icu_req,
	output ic_pkg::ic_type_t    icu_type,
	output logic [1:0]          icu_size,
	output logic [1:0]          fill_word_addr,
	output logic                ic_drty,
	output logic                icu_bypass_q,
	output logic                icu_in_powerdown,
	output logic                stall_valid,
	output logic                fourth_fill_d1,
	output logic                nc_fill_d1
);

	ic_pkg::miss_state_e next_state;
	logic normal_ack;
	logic error_ack;
	logic any_ack;
	logic diag_window;
	logic nc_req;
	logic nc_fill_cyc;
	logic fourth_fill_cyc;
	logic set_stall;

	assign normal_ack  = (biu_icu_ack == ic_pkg::ACK_NORMAL);
	assign error_ack   = biu_icu_ack[1];
	assign any_ack     = normal_ack | error_ack;
	// a diagnostic in E or C freezes the FSM in idle
	assign diag_window = valid_diag_e | valid_diag_c;

	assign ic_idle = (miss_state == ic_pkg::IDLE);
	assign nc_req  = (miss_state == ic_pkg::NC_REQ);

	// miss: cache off, boot mode or tag mismatch, only while idle
	// hit data is not trusted right after a fill, an error or a wake-up
	assign icu_miss = (!qual_ice | iu_psr_bm8 | !icu_hit) & ic_idle &
		!valid_diag_c & !fourth_fill_d1 & !nc_fill_d1 & !ic_drty & !standby_d1;

	// *******************************************************************
	// next state
	// *******************************************************************

	always_comb begin
		next_state = miss_state;
		case (miss_state)
			ic_pkg::IDLE: begin
				// power-down wins unless a branch or a diagnostic is pending
				if (pcsu_powerdown & !iu_brtaken_e & !diag_window) begin
					next_state = ic_pkg::STANDBY_PWR_DN;
				end else if (diag_window | ibuf_full | iu_brtaken_e) begin
					next_state = ic_pkg::IDLE;
				end else if (icu_miss) begin
					next_state = cacheable ? ic_pkg::REQ : ic_pkg::NC_REQ;
				end
			end
			ic_pkg::NC_REQ: begin
				if (any_ack) begin
					next_state = ic_pkg::IDLE;
				end
			end
			ic_pkg::REQ: begin
				if (normal_ack) begin
					next_state = ic_pkg::FILL_2ND;
				end else if (error_ack) begin
					next_state = ic_pkg::IDLE;
				end
			end
			ic_pkg::FILL_2ND: begin
				if (normal_ack) begin
					next_state = ic_pkg::REQ_2;
				end else if (error_ack) begin
					next_state = ic_pkg::IDLE;
				end
			end
			ic_pkg::REQ_2: begin
				if (normal_ack) begin
					next_state = ic_pkg::FILL_4TH;
				end else if (error_ack) begin
					next_state = ic_pkg::IDLE;
				end
			end
			ic_pkg::FILL_4TH: begin
				if (any_ack) begin
					next_state = ic_pkg::IDLE;
				end
			end
			ic_pkg::STANDBY_PWR_DN: begin
				// a taken branch wakes the unit as well
				if (!pcsu_powerdown | iu_brtaken_e) begin
					next_state = ic_pkg::IDLE;
				end
			end
			default: next_state = ic_pkg::IDLE;
		endcase
	end

	// last word of a line or of a single-word access
	assign nc_fill_cyc     = nc_req & any_ack;
	assign fourth_fill_cyc = (miss_state == ic_pkg::FILL_4TH) & any_ack;

	// branch taken while busy, replayed once the unit is idle again
	assign set_stall = (iu_brtaken_e | stall_valid) & !ic_idle;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			miss_state     <= ic_pkg::IDLE;
			ic_drty        <= 1'b0;
			icu_bypass_q   <= 1'b0;
			stall_valid    <= 1'b0;
			nc_fill_d1     <= 1'b0;
			fourth_fill_d1 <= 1'b0;
		end else begin
			miss_state     <= next_state;
			ic_drty        <= error_ack;
			// bypass data after a single-word access or any error
			icu_bypass_q   <= nc_req | error_ack;
			stall_valid    <= set_stall;
			nc_fill_d1     <= nc_fill_cyc & !stall_valid;
			fourth_fill_d1 <= fourth_fill_cyc & !stall_valid;
		end
	end

	// *******************************************************************
	// state decode to the bus unit
	// *******************************************************************

	assign icu_req = nc_req | (miss_state == ic_pkg::REQ);
	// always a load, non-cacheable flag in bit 1
	assign icu_type = {2'b00, nc_req, 1'b0};
	// byte in boot mode, word otherwise
	assign icu_size = {!iu_psr_bm8, 1'b0};

	// word within the line being filled
	assign fill_word_addr[1] = (miss_state == ic_pkg::REQ_2) |
		(miss_state == ic_pkg::FILL_4TH);
	assign fill_word_addr[0] = (miss_state == ic_pkg::FILL_2ND) |
		(miss_state == ic_pkg::FILL_4TH);

	// clock may be stopped while this is high
	assign icu_in_powerdown = (miss_state == ic_pkg::STANDBY_PWR_DN) & !iu_brtaken_e;

	a_state_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot(miss_state))
		else $error("miss state lost its one-hot encoding");

	// the request follows the state, so an error returns it low at once
	a_req_states: assert property (@(posedge clk) disable iff (!arst_n)
		icu_req && error_ack |=> !icu_req && ic_idle)
		else $error("request still high after an error acknowledge");

endmodule

`default_nettype wire

//--- src/ic_array_ctl.sv
// write enables and input selects for the tag and instruction arrays
// diagnostic accesses and flushes are honoured only while the unit is idle
// instruction ram is split in an even and an odd word half

`timescale 1ns/1ps
`default_nettype none

module ic_array_ctl (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire [3:0]           iu_ic_diag_e,
	input  wire                 iu_flush_e,
	input  wire                 iu_psr_ice,
	input  wire                 iu_data_e_0,
	input  wire                 misc_wrd_sel,
	input  ic_pkg::biu_ack_e    biu_icu_ack,
	input  ic_pkg::miss_state_e miss_state,
	input  wire                 ic_idle,
	output logic                valid_diag_e,
	output logic                valid_diag_c,
	output logic                diag_ld_cache_c,
	output logic                icu_itag_we,
	output logic [1:0]          icu_ram_we,
	output logic                icu_tag_vld,
	output logic                icu_tag_sel,
	output logic                ic_data_sel,
	output logic                bypass_ack
);

	logic normal_ack;
	logic word_ack;
	logic qual_flush_e;
	logic diag_st_cache_e;
	logic diag_ld_cache_e;
	logic diag_st_tag_e;
	logic fill_cyc;
	logic even_fill;
	logic odd_fill;

	assign normal_ack = (biu_icu_ack == ic_pkg::ACK_NORMAL);
	// normal or error, either way a word is on the bus
	assign word_ack   = normal_ack | biu_icu_ack[1];

	// flush is a nop with the cache off
	assign qual_flush_e = iu_flush_e & iu_psr_ice & ic_idle;

	// diag bits: 3 cache store, 2 cache load, 1 tag store, 0 tag load
	assign diag_st_cache_e = iu_ic_diag_e[3] & ic_idle;
	assign diag_ld_cache_e = iu_ic_diag_e[2] & ic_idle;
	assign diag_st_tag_e   = iu_ic_diag_e[1] & ic_idle;

	assign valid_diag_e = qual_flush_e | ((|iu_ic_diag_e) & ic_idle);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_diag_c    <= 1'b0;
			diag_ld_cache_c <= 1'b0;
		end else begin
			valid_diag_c    <= valid_diag_e;
			diag_ld_cache_c <= diag_ld_cache_e;
		end
	end

	// *******************************************************************
	// fill and diagnostic writes
	// *******************************************************************

	// words 0 and 2 land in the even half, 1 and 3 in the odd half
	assign even_fill = (miss_state == ic_pkg::REQ) | (miss_state == ic_pkg::REQ_2);
	assign odd_fill  = (miss_state == ic_pkg::FILL_2ND) | (miss_state == ic_pkg::FILL_4TH);
	assign fill_cyc  = (even_fill | odd_fill) & word_ack;

	// tag is written invalid on early words and valid on the last one
	assign icu_itag_we   = fill_cyc | diag_st_tag_e | qual_flush_e;
	assign icu_ram_we[1] = (even_fill & normal_ack) | (diag_st_cache_e & !misc_wrd_sel);
	assign icu_ram_we[0] = (odd_fill & normal_ack) | (diag_st_cache_e & misc_wrd_sel);

	// flush forces the valid bit low
	assign icu_tag_vld = (((miss_state == ic_pkg::FILL_4TH) & normal_ack) |
		(diag_st_tag_e & iu_data_e_0)) & !qual_flush_e;

	// fill address to the tags, else the diagnostic data
	assign icu_tag_sel = normal_ack | (ic_idle & !valid_diag_e);
	assign ic_data_sel = word_ack;
	assign bypass_ack  = word_ack;

	a_no_ram_we_nc: assert property (@(posedge clk) disable iff (!arst_n)
		miss_state == ic_pkg::NC_REQ |-> icu_ram_we == 2'b00)
		else $error("ram write during a non-cacheable access");

endmodule

`default_nettype wire

//--- src/ic_fetch_ctl.sv
// fetch-side status toward the instruction buffer and the pipe
// cache enable is sampled while idle, with no line-alignment check
// stall is high for one cycle after reset since no fetch data is valid

`timescale 1ns/1ps
`default_nettype none

module ic_fetch_ctl (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              iu_psr_ice,
	input  wire              iu_psr_bm8,
	input  wire              iu_flush_e,
	input  wire [3:0]        iu_ic_diag_e,
	input  wire              ibuf_full,
	input  wire              ic_idle,
	input  wire              icu_miss,
	input  wire              stall_valid,
	input  wire              fourth_fill_d1,
	input  wire              nc_fill_d1,
	input  wire              valid_diag_e,
	input  wire              valid_diag_c,
	input  wire              icu_in_powerdown,
	input  ic_pkg::biu_ack_e biu_icu_ack,
	output logic             icu_stall,
	output logic             icu_hold,
	output logic [3:0]       next_fetch_inc,
	output logic             cacheable,
	output logic             qual_ice,
	output logic             standby_d1,
	output logic             icram_powerdown
);

	logic qual_ice_q;
	logic qual_ice_sel;
	logic reset_d1_n;
	logic diag_window;

	assign diag_window = valid_diag_e | valid_diag_c;

	// *******************************************************************
	// cache enable
	// *******************************************************************

	// take the new enable only with no fill result or diagnostic in flight
	assign qual_ice_sel = ic_idle & !valid_diag_c & !nc_fill_d1 & !fourth_fill_d1;
	assign qual_ice     = qual_ice_sel ? iu_psr_ice : qual_ice_q;

	// boot code is never cached
	assign cacheable = qual_ice & !iu_psr_bm8;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			qual_ice_q  <= 1'b0;
			reset_d1_n  <= 1'b0;
			standby_d1  <= 1'b0;
		end else begin
			qual_ice_q <= qual_ice;
			reset_d1_n <= 1'b1;
			// first idle cycle after standby has no valid fetch data
			standby_d1 <= icu_in_powerdown;
		end
	end

	// *******************************************************************
	// stall and hold
	// *******************************************************************

	// data on the buffer bus is not valid when any of these holds
	assign icu_stall = icu_miss | !ic_idle | diag_window | stall_valid |
		ibuf_full | standby_d1 | !reset_d1_n | fourth_fill_d1;

	// diagnostic or flush must wait for the outstanding transaction
	assign icu_hold = ((|iu_ic_diag_e) | (iu_flush_e & iu_psr_ice)) & !ic_idle;

	// byte steps in boot mode, else word or double word
	assign next_fetch_inc = iu_psr_bm8 ? ic_pkg::INC_BOOT :
		(qual_ice ? ic_pkg::INC_LINE : ic_pkg::INC_WORD);

	// ram sleeps while the unit waits on the bus
	assign icram_powerdown = !ic_idle & (biu_icu_ack != ic_pkg::ACK_NORMAL) & !diag_window;

endmodule

`default_nettype wire

//--- src/ic_cntl.sv
// top of the instruction-cache control unit
// three peers share the miss state: FSM, array control, fetch control
// no address path here, so no fetch or bus address selects come out
// acknowledge from the bus unit is a 2-bit strobe, request is a level

`timescale 1ns/1ps
`default_nettype none

module ic_cntl (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              iu_psr_bm8,
	input  wire              iu_psr_ice,
	input  wire              iu_flush_e,
	input  wire [3:0]        iu_ic_diag_e,
	input  wire              iu_brtaken_e,
	input  wire              ibuf_full,
	input  wire              iu_data_e_0,
	input  wire              icu_hit,
	input  ic_pkg::biu_ack_e biu_icu_ack,
	input  wire              pcsu_powerdown,
	input  wire              misc_wrd_sel,
	output logic             icu_req,
	output ic_pkg::ic_type_t icu_type,
	output logic [1:0]       icu_size,
	output logic             ic_drty,
	output logic             icu_stall,
	output logic             icu_hold,
	output logic             icu_tag_vld,
	output logic             icu_itag_we,
	output logic [1:0]       icu_ram_we,
	output logic             icu_tag_sel,
	output logic             ic_data_sel,
	output logic             icu_bypass_q,
	output logic             bypass_ack,
	output logic             diag_ld_cache_c,
	output logic [1:0]       fill_word_addr,
	output logic             icu_in_powerdown,
	output logic             icram_powerdown,
	output logic [3:0]       next_fetch_inc
);

	// *******************************************************************
	// links between the peers
	// *******************************************************************

	// from the FSM
	ic_pkg::miss_state_e miss_state;
	logic ic_idle;
	logic icu_miss;
	logic stall_valid;
	logic fourth_fill_d1;
	logic nc_fill_d1;
	// from the array control
	logic valid_diag_e;
	logic valid_diag_c;
	// from the fetch control
	logic cacheable;
	logic qual_ice;
	logic standby_d1;

	ic_miss_fsm u_miss_fsm (
		.clk              (clk),
		.arst_n           (arst_n),
		.biu_icu_ack      (biu_icu_ack),
		.icu_hit          (icu_hit),
		.iu_brtaken_e     (iu_brtaken_e),
		.ibuf_full        (ibuf_full),
		.pcsu_powerdown   (pcsu_powerdown),
		.iu_psr_bm8       (iu_psr_bm8),
		.cacheable        (cacheable),
		.qual_ice         (qual_ice),
		.standby_d1       (standby_d1),
		.valid_diag_e     (valid_diag_e),
		.valid_diag_c     (valid_diag_c),
		.miss_state       (miss_state),
		.ic_idle          (ic_idle),
		.icu_miss         (icu_miss),
		.icu_req          (icu_req),
		.icu_type         (icu_type),
		.icu_size         (icu_size),
		.fill_word_addr   (fill_word_addr),
		.ic_drty          (ic_drty),
		.icu_bypass_q     (icu_bypass_q),
		.icu_in_powerdown (icu_in_powerdown),
		.stall_valid      (stall_valid),
		.fourth_fill_d1   (fourth_fill_d1),
		.nc_fill_d1       (nc_fill_d1)
	);

	// diagnostics only ever act in idle, so no arbitration with fills
	ic_array_ctl u_array_ctl (
		.clk             (clk),
		.arst_n          (arst_n),
		.iu_ic_diag_e    (iu_ic_diag_e),
		.iu_flush_e      (iu_flush_e),
		.iu_psr_ice      (iu_psr_ice),
		.iu_data_e_0     (iu_data_e_0),
		.misc_wrd_sel    (misc_wrd_sel),
		.biu_icu_ack     (biu_icu_ack),
		.miss_state      (miss_state),
		.ic_idle         (ic_idle),
		.valid_diag_e    (valid_diag_e),
		.valid_diag_c    (valid_diag_c),
		.diag_ld_cache_c (diag_ld_cache_c),
		.icu_itag_we     (icu_itag_we),
		.icu_ram_we      (icu_ram_we),
		.icu_tag_vld     (icu_tag_vld),
		.icu_tag_sel     (icu_tag_sel),
		.ic_data_sel     (ic_data_sel),
		.bypass_ack      (bypass_ack)
	);

	ic_fetch_ctl u_fetch_ctl (
		.clk              (clk),
		.arst_n           (arst_n),
		.iu_psr_ice       (iu_psr_ice),
		.iu_psr_bm8       (iu_psr_bm8),
		.iu_flush_e       (iu_flush_e),
		.iu_ic_diag_e     (iu_ic_diag_e),
		.ibuf_full        (ibuf_full),
		.ic_idle          (ic_idle),
		.icu_miss         (icu_miss),
		.stall_valid      (stall_valid),
		.fourth_fill_d1   (fourth_fill_d1),
		.nc_fill_d1       (nc_fill_d1),
		.valid_diag_e     (valid_diag_e),
		.valid_diag_c     (valid_diag_c),
		.icu_in_powerdown (icu_in_powerdown),
		.biu_icu_ack      (biu_icu_ack),
		.icu_stall        (icu_stall),
		.icu_hold         (icu_hold),
		.next_fetch_inc   (next_fetch_inc),
		.cacheable        (cacheable),
		.qual_ice         (qual_ice),
		.standby_d1       (standby_d1),
		.icram_powerdown  (icram_powerdown)
	);

endmodule

`default_nettype wire

//--- verif/ic_ref_model.svh
// reference model of the miss FSM for the testbench
// covers the fill sequence, array write enables and fetch increment
// included inside the testbench module, so it holds functions only

// state after one cycle of a fill or single-word access
function automatic ic_pkg::miss_state_e model_next(input ic_pkg::miss_state_e s,
		input ic_pkg::biu_ack_e ack);
	if (ack == ic_pkg::ACK_NONE) begin
		return s;
	end
	// bit 1 of the acknowledge always aborts
	if (ack[1]) begin
		return ic_pkg::IDLE;
	end
	case (s)
		ic_pkg::REQ:      return ic_pkg::FILL_2ND;
		ic_pkg::FILL_2ND: return ic_pkg::REQ_2;
		ic_pkg::REQ_2:    return ic_pkg::FILL_4TH;
		default:          return ic_pkg::IDLE;
	endcase
endfunction

// request is a level in the two request states
function automatic logic model_req(input ic_pkg::miss_state_e s);
	return (s == ic_pkg::NC_REQ) || (s == ic_pkg::REQ);
endfunction

// word of the line being filled, zero outside a fill
function automatic logic [1:0] model_word(input ic_pkg::miss_state_e s);
	case (s)
		ic_pkg::FILL_2ND: return 2'd1;
		ic_pkg::REQ_2:    return 2'd2;
		ic_pkg::FILL_4TH: return 2'd3;
		default:          return 2'd0;
	endcase
endfunction

// even words write the upper enable, odd words the lower one
function automatic logic [1:0] model_ram_we(input ic_pkg::miss_state_e s,
		input ic_pkg::biu_ack_e ack);
	logic [1:0] word;
	if (ack != ic_pkg::ACK_NORMAL || s == ic_pkg::NC_REQ || s == ic_pkg::IDLE) begin
		return 2'b00;
	end
	word = model_word(s);
	return word[0] ? 2'b01 : 2'b10;
endfunction

// fetch step in bytes
function automatic logic [3:0] model_inc(input logic bm8, input logic ice);
	if (bm8) begin
		return 4'd1;
	end
	return ice ? 4'd8 : 4'd4;
endfunction

//--- verif/tb_ic_cntl.sv
// testbench for the instruction-cache control unit
// random acknowledge delays and abort points, fixed seed
// outputs are sampled on the falling edge, inputs move 1 ns after rising

`timescale 1ns/1ps
`default_nettype none

module tb_ic_cntl;

	logic clk;
	logic arst_n;
	logic iu_psr_bm8;
	logic iu_psr_ice;
	logic iu_flush_e;
	logic [3:0] iu_ic_diag_e;
	logic iu_brtaken_e;
	logic ibuf_full;
	logic iu_data_e_0;
	logic icu_hit;
	ic_pkg::biu_ack_e biu_icu_ack;
	logic pcsu_powerdown;
	logic misc_wrd_sel;
	logic icu_req;
	ic_pkg::ic_type_t icu_type;
	logic [1:0] icu_size;
	logic ic_drty;
	logic icu_stall;
	logic icu_hold;
	logic icu_tag_vld;
	logic icu_itag_we;
	logic [1:0] icu_ram_we;
	logic icu_tag_sel;
	logic ic_data_sel;
	logic icu_bypass_q;
	logic bypass_ack;
	logic diag_ld_cache_c;
	logic [1:0] fill_word_addr;
	logic icu_in_powerdown;
	logic icram_powerdown;
	logic [3:0] next_fetch_inc;
	int seed_val;

	`include "ic_ref_model.svh"

	ic_cntl dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// *******************************************************************
	// failure reporting and compare tasks
	// *******************************************************************

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at %0t", $time);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %0b expected %0b", $time, name, got, exp);
			stop_run("single-bit output mismatch");
		end
	endtask

	task automatic check_nib(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
			stop_run("multi-bit output mismatch");
		end
	endtask

	// state seen through request, word address and type
	task automatic check_state(input ic_pkg::miss_state_e exp);
		check_bit({"icu_req in ", exp.name()}, icu_req, model_req(exp));
		check_nib({"fill_word_addr in ", exp.name()}, {2'b00, fill_word_addr},
			{2'b00, model_word(exp)});
		check_nib({"icu_type in ", exp.name()}, icu_type,
			(exp == ic_pkg::NC_REQ) ? 4'h2 : 4'h0);
	endtask

	task automatic tick;
		@(posedge clk);
		#1;
	endtask

	// wait until the unit stops stalling the buffer
	task automatic wait_quiet;
		int n;
		n = 0;
		@(negedge clk);
		while (icu_stall) begin
			if (n == 30) begin
				stop_run("timeout waiting for the stall to clear");
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic wait_req;
		int n;
		n = 0;
		@(negedge clk);
		while (!icu_req) begin
			if (n == 30) begin
				stop_run("timeout waiting for a bus request");
			end
			n++;
			@(negedge clk);
		end
	endtask

	// bus responder for a line fill, err_word of 4 means no error
	task automatic run_fill(input int err_word);
		ic_pkg::miss_state_e st;
		ic_pkg::biu_ack_e ack;
		int dly;
		st = ic_pkg::REQ;
		for (int w = 0; w < 4; w++) begin
			dly = $urandom % 6;
			repeat (dly) begin
				tick();
				biu_icu_ack = ic_pkg::ACK_NONE;
				// flush while busy has to be held off
				iu_flush_e = 1'b1;
				@(negedge clk);
				check_state(st);
				check_nib("icu_ram_we idle", {2'b00, icu_ram_we}, 4'h0);
				check_bit("icu_itag_we wait", icu_itag_we, 1'b0);
				check_bit("icram_powerdown", icram_powerdown, 1'b1);
				check_bit("icu_hold busy", icu_hold, 1'b1);
				check_bit("icu_tag_sel wait", icu_tag_sel, 1'b0);
				check_bit("ic_data_sel wait", ic_data_sel, 1'b0);
				check_bit("bypass_ack wait", bypass_ack, 1'b0);
			end
			tick();
			if (w == err_word) begin
				ack = ($urandom % 2) ? ic_pkg::ACK_ERROR : ic_pkg::ACK_ERROR_ALT;
			end else begin
				ack = ic_pkg::ACK_NORMAL;
			end
			biu_icu_ack = ack;
			iu_flush_e = 1'b0;
			@(negedge clk);
			check_state(st);
			check_nib("icu_ram_we", {2'b00, icu_ram_we}, {2'b00, model_ram_we(st, ack)});
			check_bit("icu_itag_we", icu_itag_we, 1'b1);
			check_bit("icu_tag_vld", icu_tag_vld,
				st == ic_pkg::FILL_4TH && ack == ic_pkg::ACK_NORMAL);
			check_bit("icu_hold", icu_hold, 1'b0);
			check_bit("icu_tag_sel", icu_tag_sel, ack == ic_pkg::ACK_NORMAL);
			check_bit("ic_data_sel", ic_data_sel, 1'b1);
			check_bit("bypass_ack", bypass_ack, 1'b1);
			st = model_next(st, ack);
			if (ack[1]) begin
				break;
			end
		end
		tick();
		biu_icu_ack = ic_pkg::ACK_NONE;
		@(negedge clk);
		check_state(st);
		check_nib("icu_ram_we after", {2'b00, icu_ram_we}, 4'h0);
		check_bit("icu_tag_vld after", icu_tag_vld, 1'b0);
		check_bit("ic_drty", ic_drty, err_word < 4);
		check_bit("icu_bypass_q after", icu_bypass_q, err_word < 4);
	endtask

	// miss in idle, request exactly one cycle later
	task automatic start_fill;
		tick();
		icu_hit = 1'b0;
		@(negedge clk);
		check_state(ic_pkg::IDLE);
		check_bit("icu_stall on miss", icu_stall, 1'b1);
		tick();
		icu_hit = 1'b1;
		@(negedge clk);
		check_state(ic_pkg::REQ);
		check_nib("icu_size", {2'b00, icu_size}, 4'h2);
	endtask

	// *******************************************************************
	// stimulus
	// *******************************************************************

	initial begin
		logic bit_r;
		seed_val = $urandom(32'h5753_7f4f);
		arst_n = 1'b0;
		iu_psr_bm8 = 1'b0;
		iu_psr_ice = 1'b1;
		iu_flush_e = 1'b0;
		iu_ic_diag_e = 4'h0;
		iu_brtaken_e = 1'b0;
		ibuf_full = 1'b0;
		iu_data_e_0 = 1'b0;
		icu_hit = 1'b1;
		biu_icu_ack = ic_pkg::ACK_NONE;
		pcsu_powerdown = 1'b0;
		misc_wrd_sel = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("icu_stall after reset", icu_stall, 1'b1);
		check_state(ic_pkg::IDLE);
		check_bit("icu_in_powerdown after reset", icu_in_powerdown, 1'b0);
		check_bit("icu_bypass_q after reset", icu_bypass_q, 1'b0);
		check_nib("icu_ram_we after reset", {2'b00, icu_ram_we}, 4'h0);
		check_bit("icu_tag_sel idle", icu_tag_sel, 1'b1);
		wait_quiet();

		// cacheable fills, then fills aborted on a random word
		repeat (6) begin
			start_fill();
			run_fill(4);
			wait_quiet();
		end
		repeat (4) begin
			start_fill();
			run_fill($urandom % 4);
			wait_quiet();
		end

		// non-cacheable single word
		repeat (3) begin
			tick();
			iu_psr_ice = 1'b0;
			wait_req();
			check_state(ic_pkg::NC_REQ);
			repeat ($urandom % 6) begin
				tick();
				@(negedge clk);
				check_state(ic_pkg::NC_REQ);
			end
			tick();
			biu_icu_ack = ic_pkg::ACK_NORMAL;
			@(negedge clk);
			check_nib("icu_ram_we nc", {2'b00, icu_ram_we}, 4'h0);
			tick();
			biu_icu_ack = ic_pkg::ACK_NONE;
			iu_psr_ice = 1'b1;
			@(negedge clk);
			check_state(ic_pkg::IDLE);
			check_bit("icu_bypass_q nc", icu_bypass_q, 1'b1);
			wait_quiet();
		end

		// diagnostics: tag store, cache store, cache load
		repeat (4) begin
			bit_r = $urandom % 2;
			tick();
			iu_ic_diag_e = 4'b0010;
			iu_data_e_0 = bit_r;
			@(negedge clk);
			check_bit("icu_itag_we diag", icu_itag_we, 1'b1);
			check_bit("icu_tag_vld diag", icu_tag_vld, bit_r);
			check_bit("icu_stall diag", icu_stall, 1'b1);
			check_bit("icu_tag_sel diag", icu_tag_sel, 1'b0);
			check_bit("icu_hold diag", icu_hold, 1'b0);
			tick();
			iu_ic_diag_e = 4'b1000;
			misc_wrd_sel = bit_r;
			@(negedge clk);
			check_nib("icu_ram_we diag", {2'b00, icu_ram_we}, bit_r ? 4'h1 : 4'h2);
			check_bit("icu_stall diag", icu_stall, 1'b1);
			tick();
			iu_ic_diag_e = 4'b0100;
			@(negedge clk);
			check_bit("icu_stall diag", icu_stall, 1'b1);
			tick();
			iu_ic_diag_e = 4'b0000;
			@(negedge clk);
			check_bit("diag_ld_cache_c", diag_ld_cache_c, 1'b1);
			check_bit("icu_stall diag", icu_stall, 1'b1);
			wait_quiet();
		end

		// power-down and release
		tick();
		pcsu_powerdown = 1'b1;
		@(negedge clk);
		check_bit("icu_in_powerdown", icu_in_powerdown, 1'b0);
		repeat (2 + $urandom % 4) begin
			tick();
			@(negedge clk);
			check_bit("icu_in_powerdown", icu_in_powerdown, 1'b1);
			check_bit("icu_req in standby", icu_req, 1'b0);
		end
		tick();
		pcsu_powerdown = 1'b0;
		@(negedge clk);
		check_bit("icu_in_powerdown release", icu_in_powerdown, 1'b1);
		tick();
		@(negedge clk);
		check_bit("icu_in_powerdown cleared", icu_in_powerdown, 1'b0);
		wait_quiet();

		// fetch increment, full buffer keeps the unit idle
		tick();
		ibuf_full = 1'b1;
		iu_psr_bm8 = 1'b1;
		@(negedge clk);
		check_nib("next_fetch_inc", next_fetch_inc, model_inc(1'b1, 1'b1));
		for (int i = 0; i < 2; i++) begin
			tick();
			iu_psr_bm8 = 1'b0;
			iu_psr_ice = i[0];
			repeat (2) tick();
			@(negedge clk);
			check_nib("next_fetch_inc", next_fetch_inc, model_inc(1'b0, i[0]));
		end
		tick();
		ibuf_full = 1'b0;
		wait_quiet();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+verif
src/ic_pkg.sv
src/ic_miss_fsm.sv
src/ic_array_ctl.sv
src/ic_fetch_ctl.sv
src/ic_cntl.sv
verif/tb_ic_cntl.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_ic_cntl -o sim_ic_cntl

if ! out=$(./obj_dir/sim_ic_cntl); then
	echo "$out"
	exit 1
fi
echo "$out"
echo "$out" | grep -q "TEST PASS"
